/* compile.f */
hw/rom_loader_pkg.sv
hw/boot_word_intake.sv
hw/word_byte_fifo.sv
hw/rom_byte_fetch.sv
hw/ines_loader.sv
hw/mapper_flags_decode.sv
hw/rom_loader_top.sv
bench/tb_clkgen.sv
bench/tb_rom_loader.sv

/* Bender.yml */
package:
  name: rom_loader

sources:
  - files:
      - hw/rom_loader_pkg.sv
      - hw/boot_word_intake.sv
      - hw/word_byte_fifo.sv
      - hw/rom_byte_fetch.sv
      - hw/ines_loader.sv
      - hw/mapper_flags_decode.sv
      - hw/rom_loader_top.sv
  - target: test
    files:
      - bench/tb_clkgen.sv
      - bench/tb_rom_loader.sv

/* bench/tb_rom_loader.sv */
// Directed tests of the ROM download path; long ROM cases make the run take over a million cycles
`timescale 1ns/1ps

module tb_rom_loader;

	import rom_loader_pkg::*;

	localparam int FIFO_WORDS  = 16;
	localparam int BYTE_PERIOD = 16;
	localparam int ACK_LIMIT   = 8 * 4 * BYTE_PERIOD;  // Several word drain times
	localparam int TOTAL_BYTES = 24592 + 2 * 32784 + 32 + 64 + 160;
	localparam int WATCHDOG_CYCLES = TOTAL_BYTES * BYTE_PERIOD * 4 + 20000;

	logic clk, host_reset_loader, restart;
	logic [31:0] boot_data;
	logic boot_req, boot_ack_o, host_run;
	rom_kind_t file_kind;
	logic [MEM_ADDR_W-1:0] mem_addr_o;
	logic [7:0] mem_data_o;
	logic mem_write_o, done_o, error_o, downloading_o;
	logic [FLAGS_W-1:0] flags_o;

	logic [7:0]            stream [$];  // Bytes the host sends
	logic [MEM_ADDR_W-1:0] exp_addr [$];
	logic [7:0]            exp_data [$];
	logic [MEM_ADDR_W-1:0] got_addr [$];
	logic [7:0]            got_data [$];
	logic [31:0] lfsr = 32'd89122;
	int mismatch_count = 0;
	int fail_count = 0;
	int max_ack_wait;

	tb_clkgen #(.PERIOD_NS(10), .RST_CYCLES(3)) i_tb_clkgen (
		.restart_i (restart), .clk, .host_reset_loader
	);

	rom_loader_top #(.FIFO_WORDS(FIFO_WORDS), .BYTE_PERIOD(BYTE_PERIOD)) i_rom_loader_top (
		.clk, .host_reset_loader, .boot_data_i (boot_data), .boot_req_i (boot_req),
		.boot_ack_o, .file_kind_i (file_kind), .host_run_i (host_run),
		.mem_addr_o, .mem_data_o, .mem_write_o, .flags_o, .done_o, .error_o, .downloading_o
	);

	// Write monitor collects one entry per strobe
	always @(negedge clk) begin
		if (!host_reset_loader && mem_write_o === 1'b1) begin
			got_addr.push_back(mem_addr_o);
			got_data.push_back(mem_data_o);
		end
	end

	// ----------------------------------------
	// Stimulus helpers
	// ----------------------------------------
	function automatic logic [7:0] rand_byte();
		logic [7:0] b;
		logic fb;
		for (int i = 0; i < 8; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];  // x^32+x^22+x^2+x+1
			lfsr = {lfsr[30:0], fb};
			b    = {b[6:0], fb};
		end
		return b;
	endfunction

	// Flags word packed from the field layout
	function automatic logic [31:0] make_flags(input logic [7:0] mapper, input logic [2:0] prg,
			input logic [2:0] chr, input logic mirror, input logic chr_ram, input logic [7:0] ext);
		return {7'd0, ext, 1'b0, chr_ram, mirror, chr, prg, mapper};
	endfunction

	task automatic start_test(input rom_kind_t kind, input string name);
		$display("Running %s", name);
		@(negedge clk);
		file_kind = kind;  // Loader picks its start address in reset
		boot_req  = 1'b0;
		host_run  = 1'b0;
		restart   = 1'b1;
		@(negedge clk);
		restart = 1'b0;
		@(negedge clk);
		while (host_reset_loader)
			@(negedge clk);
		stream.delete();
		exp_addr.delete();
		exp_data.delete();
		got_addr.delete();
		got_data.delete();
		max_ack_wait = 0;
	endtask

	task automatic push_header(input logic [127:0] h);
		for (int i = 0; i < 16; i++) begin
			stream.push_back(h[127-8*i -: 8]);  // Byte 0 first
			exp_addr.push_back(i);
			exp_data.push_back(h[127-8*i -: 8]);
		end
	endtask

	task automatic push_payload(input int n, input logic [MEM_ADDR_W-1:0] base, input bit seen);
		logic [7:0] b;
		for (int i = 0; i < n; i++) begin
			b = rand_byte();
			stream.push_back(b);
			if (seen) begin
				exp_addr.push_back(base + i);
				exp_data.push_back(b);
			end
		end
	endtask

	// Host model sends big-endian words over req/ack and then raises host_run
	task automatic send_stream();
		logic [31:0] word;
		int waited;
		for (int w = 0; w < (stream.size() + 3) / 4; w++) begin
			word = '0;
			for (int k = 0; k < 4; k++)
				if (4 * w + k < stream.size())
					word[31-8*k -: 8] = stream[4*w+k];
			boot_data = word;
			boot_req  = 1'b1;
			@(negedge clk);
			waited = 1;
			while (boot_ack_o !== 1'b1 && waited < ACK_LIMIT) begin
				@(negedge clk);
				waited++;
			end
			if (waited > max_ack_wait)
				max_ack_wait = waited;
			if (boot_ack_o !== 1'b1) begin
				$display("Host got no acknowledge for word %0d in %0d cycles", w, ACK_LIMIT);
				fail_count++;
				break;
			end
		end
		boot_req = 1'b0;
		@(negedge clk);
		// Download still open until the host says so
		if (downloading_o !== 1'b1) begin
			$display("MISMATCH downloading_o: got 0x%h expected 0x1", downloading_o);
			mismatch_count++;
		end
		host_run = 1'b1;
	endtask

	// ----------------------------------------
	// Checks
	// ----------------------------------------
	task automatic wait_done();
		int limit;
		int waited;
		limit  = (stream.size() + 16) * BYTE_PERIOD * 2 + 200;
		waited = 0;
		while (done_o !== 1'b1 && waited < limit) begin
			@(negedge clk);
			waited++;
		end
		if (done_o !== 1'b1) begin
			$display("Loader did not report done within %0d cycles", limit);
			fail_count++;
		end
		repeat (4 * BYTE_PERIOD) @(negedge clk);  // Flags settle and stray writes show up
	endtask

	task automatic check_writes();
		int shown;
		shown = 0;
		if (got_addr.size() != exp_addr.size()) begin
			$display("MISMATCH mem_write_o count: got 0x%h expected 0x%h",
			         got_addr.size(), exp_addr.size());
			mismatch_count++;
		end
		for (int i = 0; i < got_addr.size() && i < exp_addr.size() && shown < 8; i++) begin
			if (got_addr[i] !== exp_addr[i] || got_data[i] !== exp_data[i]) begin
				$display("MISMATCH mem_addr_o/mem_data_o write %0d: got 0x%h/0x%h expected 0x%h/0x%h",
				         i, got_addr[i], got_data[i], exp_addr[i], exp_data[i]);
				mismatch_count++;
				shown++;
			end
		end
	endtask

	task automatic check_status(input logic exp_error, input logic [31:0] exp_flags);
		if (done_o !== 1'b1) begin
			$display("MISMATCH done_o: got 0x%h expected 0x1", done_o);
			mismatch_count++;
		end
		if (error_o !== exp_error) begin
			$display("MISMATCH error_o: got 0x%h expected 0x%h", error_o, exp_error);
			mismatch_count++;
		end
		if (flags_o !== exp_flags) begin
			$display("MISMATCH flags_o: got 0x%h expected 0x%h", flags_o, exp_flags);
			mismatch_count++;
		end
	endtask

	// ----------------------------------------
	// Directed tests
	// ----------------------------------------
	task automatic test_nes_rom();
		start_test(ROM_NES, "NES ROM, mapper 4");
		push_header(128'h4E45531A_01_01_41_00_0000000000000000);  // Vertical mirroring
		push_payload(16384, PRG_BASE, 1'b1);
		push_payload(8192, CHR_BASE, 1'b1);
		send_stream();
		wait_done();
		check_writes();
		check_status(1'b0, make_flags(8'h04, 3'd0, 3'd0, 1'b1, 1'b0, 8'h00));
	endtask

	task automatic test_header_variants();
		start_test(ROM_NES, "iNES 2.0 header");
		// Version bits in byte 7 and a nonzero byte 10
		push_header(128'h4E45531A_02_00_10_28_35_00_07_0000000000);
		push_payload(32768, PRG_BASE, 1'b1);
		send_stream();
		wait_done();
		check_writes();
		check_status(1'b0, make_flags(8'h21, 3'd1, 3'd0, 1'b0, 1'b1, 8'h35));
		start_test(ROM_NES, "dirty iNES header");
		push_header(128'h4E45531A_02_00_30_50_00_00_00_00_44_000000);  // Tag in byte 12
		push_payload(32768, PRG_BASE, 1'b1);
		send_stream();
		wait_done();
		check_writes();
		check_status(1'b0, make_flags(8'h03, 3'd1, 3'd0, 1'b0, 1'b1, 8'h00));
	endtask

	task automatic test_bad_header();
		start_test(ROM_NES, "bad header");
		push_header(128'h4241441A_00_00_00_00_0000000000000000);
		push_payload(16, PRG_BASE, 1'b0);  // Must never be written
		send_stream();
		wait_done();
		check_writes();
		check_status(1'b1, make_flags(8'h00, 3'd0, 3'd0, 1'b0, 1'b1, 8'h00));
	endtask

	task automatic test_bios_raw();
		start_test(ROM_BIOS, "BIOS raw load");
		push_header(128'h0);
		push_payload(48, BIOS_SKIP_BASE, 1'b1);
		send_stream();
		wait_done();
		if (downloading_o !== 1'b0) begin
			$display("MISMATCH downloading_o: got 0x%h expected 0x0", downloading_o);
			mismatch_count++;
		end
		check_writes();
		check_status(1'b0, make_flags(8'h14, 3'd7, 3'd0, 1'b0, 1'b1, 8'h00));
	endtask

	task automatic test_back_pressure();
		start_test(ROM_BIOS, "FIFO back-pressure, 40 words");
		push_payload(160, '0, 1'b1);  // Header and payload land back to back
		send_stream();
		wait_done();
		if (max_ack_wait <= 2) begin
			$display("Host was never stalled, FIFO did not fill");
			fail_count++;
		end
		check_writes();
		check_status(1'b0, make_flags(8'h14, 3'd7, 3'd0, 1'b0, 1'b1, 8'h00));
	endtask

	// ----------------------------------------
	// Run and report
	// ----------------------------------------
	initial begin
		restart   = 1'b0;
		boot_data = '0;
		boot_req  = 1'b0;
		host_run  = 1'b0;
		file_kind = ROM_NES;
		test_nes_rom();
		test_header_variants();
		test_bad_header();
		test_bios_raw();
		test_back_pressure();
		$display("Summary: %0d mismatches, %0d other failures", mismatch_count, fail_count);
		if (mismatch_count == 0 && fail_count == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
		$display("Summary: %0d mismatches, %0d other failures", mismatch_count, fail_count + 1);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

/* bench/tb_clkgen.sv */
// Testbench clock and reset; restart_i is sampled on the rising edge, reset moves on the falling edge
`timescale 1ns/1ps

module tb_clkgen #(
	parameter int PERIOD_NS  = 10,
	parameter int RST_CYCLES = 3
) (
	input  logic restart_i,
	output logic clk,
	output logic host_reset_loader
);

	int rst_cnt = RST_CYCLES;  // Reset cycles still owed

	initial clk = 1'b0;
	always #(PERIOD_NS / 2) clk = ~clk;

	initial host_reset_loader = 1'b1;  // Held from time zero

	always @(posedge clk) begin
		if (restart_i)
			rst_cnt <= RST_CYCLES;
		else if (rst_cnt != 0)
			rst_cnt <= rst_cnt - 1;
	end

	// Edges land away from the DUT's sampling edge
	always @(negedge clk)
		host_reset_loader <= (rst_cnt != 0);

endmodule

/* hw/rom_loader_top.sv */
// ROM download top; single clock, host_run_i marks the end of the file and must stay high
`timescale 1ns/1ps

module rom_loader_top #(
	parameter int FIFO_WORDS  = 16,  // Power of two
	parameter int BYTE_PERIOD = 16   // Power of two
) (
	input  logic                                clk,
	input  logic                                host_reset_loader,
	input  logic [rom_loader_pkg::BOOT_WORD_W-1:0] boot_data_i,
	input  logic                                boot_req_i,
	output logic                                boot_ack_o,
	input  rom_loader_pkg::rom_kind_t           file_kind_i,
	input  logic                                host_run_i,
	output logic [rom_loader_pkg::MEM_ADDR_W-1:0]  mem_addr_o,
	output logic [7:0]                          mem_data_o,
	output logic                                mem_write_o,
	output logic [rom_loader_pkg::FLAGS_W-1:0]  flags_o,
	output logic                                done_o,
	output logic                                error_o,
	output logic                                downloading_o
);

	import rom_loader_pkg::*;

	logic                      fifo_wr;
	logic [BOOT_WORD_W-1:0]    fifo_word;
	logic                      fifo_full;
	logic                      fifo_rd;
	logic [7:0]                fifo_byte;
	logic                      fifo_empty;
	logic                      byte_stb;
	logic [7:0]                byte_data;
	logic [HDR_BYTES-1:0][7:0] header;

	// ----------------------------------------
	// Producer, buffer, consumer
	// ----------------------------------------
	boot_word_intake i_boot_word_intake (
		.clk, .host_reset_loader,
		.boot_data_i, .boot_req_i, .boot_ack_o,
		.fifo_full_i (fifo_full), .fifo_wr_o (fifo_wr), .fifo_word_o (fifo_word)
	);

	word_byte_fifo #(.FIFO_WORDS(FIFO_WORDS)) i_word_byte_fifo (
		.clk, .host_reset_loader,
		.wr_en_i (fifo_wr), .wr_word_i (fifo_word), .full_o (fifo_full),
		.rd_en_i (fifo_rd), .rd_byte_o (fifo_byte), .empty_o (fifo_empty)
	);

	rom_byte_fetch #(.BYTE_PERIOD(BYTE_PERIOD)) i_rom_byte_fetch (
		.clk, .host_reset_loader,
		.fifo_empty_i (fifo_empty), .fifo_rd_o (fifo_rd), .fifo_byte_i (fifo_byte),
		.loader_done_i (done_o), .host_run_i,
		.byte_stb_o (byte_stb), .byte_data_o (byte_data), .downloading_o
	);

	ines_loader i_ines_loader (
		.clk, .host_reset_loader, .file_kind_i,
		.downloading_i (downloading_o), .byte_stb_i (byte_stb), .byte_data_i (byte_data),
		.mem_addr_o, .mem_data_o, .mem_write_o,
		.header_o (header), .done_o, .error_o
	);

	mapper_flags_decode i_mapper_flags_decode (
		.clk, .host_reset_loader,
		.header_i (header), .done_i (done_o), .flags_o
	);

endmodule

/* hw/mapper_flags_decode.sv */
// Mapper flags from the iNES header; the flags word only changes while the loader reports done
`timescale 1ns/1ps

module mapper_flags_decode (
	input  logic                                     clk,
	input  logic                                     host_reset_loader,
	input  logic [rom_loader_pkg::HDR_BYTES-1:0][7:0] header_i,
	input  logic                                     done_i,
	output logic [rom_loader_pkg::FLAGS_W-1:0]       flags_o
);

	import rom_loader_pkg::*;

	logic               is_nes20;
	logic               is_dirty;
	logic [7:0]         mapper;
	logic [FLAGS_W-1:0] flags_next;

	// Smallest power-of-two code that covers the page count
	function automatic logic [2:0] size_code(input logic [7:0] pages);
		logic [2:0] code;
		code = 3'd7;  // 128 pages and up
		for (int i = 6; i >= 0; i--)
			if (pages <= (8'd1 << i))
				code = 3'(i);
		return code;
	endfunction

	// ----------------------------------------
	// Header checks
	// ----------------------------------------
	assign is_nes20 = (header_i[7][3:2] == 2'b10);

	// Junk in the tail of an iNES 1.0 header, e.g. ripper tags
	always_comb begin
		is_dirty = (header_i[9][7:1] != 7'd0);
		for (int i = 10; i < HDR_BYTES; i++)
			is_dirty = is_dirty || (header_i[i] != 8'h00);
		is_dirty = is_dirty && !is_nes20;
	end

	assign mapper = {is_dirty ? 4'h0 : header_i[7][7:4], header_i[6][7:4]};

	// Flags word
	always_comb begin
		flags_next                         = '0;
		flags_next[FLG_MAPPER_LSB +: 8]    = mapper;
		flags_next[FLG_PRG_LSB +: 3]       = size_code(header_i[4]);
		flags_next[FLG_CHR_LSB +: 3]       = size_code(header_i[5]);
		flags_next[FLG_MIRROR_BIT]         = header_i[6][0];
		flags_next[FLG_CHR_RAM_BIT]        = (header_i[5] == 8'h00);  // No CHR ROM
		flags_next[FLG_FOUR_SCR_BIT]       = header_i[6][3];
		flags_next[FLG_EXT_LSB +: 8]       = is_nes20 ? header_i[8] : 8'h00;
	end

	always_ff @(posedge clk) begin
		if (host_reset_loader)
			flags_o <= '0;
		else if (done_i)
			flags_o <= flags_next;  // One cycle behind done
	end

endmodule

/* hw/ines_loader.sv */
// iNES/FDS loader; trainers are rejected and payload sizes come from header bytes 4 and 5
`timescale 1ns/1ps

module ines_loader (
	input  logic                                     clk,
	input  logic                                     host_reset_loader,
	input  rom_loader_pkg::rom_kind_t                file_kind_i,
	input  logic                                     downloading_i,
	input  logic                                     byte_stb_i,
	input  logic [7:0]                               byte_data_i,
	output logic [rom_loader_pkg::MEM_ADDR_W-1:0]    mem_addr_o,
	output logic [7:0]                               mem_data_o,
	output logic                                     mem_write_o,
	output logic [rom_loader_pkg::HDR_BYTES-1:0][7:0] header_o,
	output logic                                     done_o,
	output logic                                     error_o
);

	import rom_loader_pkg::*;

	load_state_t                 state;
	logic [3:0]                  ctr;         // Header byte index
	logic [MEM_ADDR_W-1:0]       bytes_left;  // Counted payload remaining
	logic [HDR_BYTES-1:0][7:0]   hdr;
	logic                        nes_sig;
	logic                        fds_sig;
	logic                        counted;

	assign header_o   = hdr;
	assign mem_data_o = byte_data_i;  // Bytes pass straight through

	// Signatures, checked once byte 15 arrives
	assign nes_sig = (hdr[0] == 8'h4E) && (hdr[1] == 8'h45) &&
	                 (hdr[2] == 8'h53) && (hdr[3] == 8'h1A);
	assign fds_sig = (hdr[0] == 8'h46) && (hdr[1] == 8'h44) &&
	                 (hdr[2] == 8'h53) && (hdr[3] == 8'h1A);

	assign counted = (state == LS_PRG || state == LS_CHR) && (bytes_left != '0);

	// Write strobe follows the byte strobe in the same cycle
	assign mem_write_o = byte_stb_i &&
	                     (counted || (downloading_i && (state == LS_HEADER || state == LS_RAW)));

	// ----------------------------------------
	// Load FSM
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (host_reset_loader) begin
			state      <= LS_HEADER;
			ctr        <= '0;
			bytes_left <= '0;
			done_o     <= 1'b0;
			error_o    <= 1'b0;
			mem_addr_o <= (file_kind_i == ROM_FDS) ? FDS_SKIP_BASE : PRG_BASE;
		end else begin
			unique case (state)
				LS_HEADER: begin
					if (byte_stb_i) begin
						ctr        <= ctr + 4'd1;
						mem_addr_o <= mem_addr_o + 1'b1;
						if (ctr == 4'd15) begin
							if (nes_sig && !hdr[6][2]) begin  // No trainer support
								state      <= LS_PRG;
								mem_addr_o <= PRG_BASE;
								bytes_left <= {hdr[4], 14'd0};  // 16 KiB pages
							end else if (fds_sig) begin
								state      <= LS_RAW;
								mem_addr_o <= FDS_SKIP_BASE;
							end else if (file_kind_i == ROM_BIOS) begin
								state      <= LS_RAW;
								mem_addr_o <= BIOS_SKIP_BASE;
							end else if (file_kind_i == ROM_FDS) begin
								state      <= LS_RAW;
								mem_addr_o <= FDS_RAW_BASE;
							end else begin
								state <= LS_BAD;
							end
						end
					end
				end
				LS_PRG, LS_CHR: begin
					if (bytes_left != '0) begin
						if (byte_stb_i) begin
							bytes_left <= bytes_left - 1'b1;
							mem_addr_o <= mem_addr_o + 1'b1;
						end
					end else if (state == LS_PRG) begin
						state      <= LS_CHR;
						mem_addr_o <= CHR_BASE;
						bytes_left <= {1'b0, hdr[5], 13'd0};  // 8 KiB pages
					end else begin
						done_o <= 1'b1;  // CHR exhausted
					end
				end
				LS_RAW: begin
					if (downloading_i) begin
						if (byte_stb_i)
							mem_addr_o <= mem_addr_o + 1'b1;
					end else begin
						done_o <= 1'b1;
					end
				end
				LS_BAD: begin
					done_o  <= 1'b1;
					error_o <= 1'b1;
				end
				default: state <= LS_BAD;
			endcase
		end
	end

	// ----------------------------------------
	// Header store
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (state == LS_HEADER && byte_stb_i) begin
			hdr[ctr] <= byte_data_i;
		end else if (state == LS_RAW && !downloading_i) begin
			// Fake header for raw images, mapper 0x14 with CHR RAM
			hdr[4] <= 8'hFF;  // No PRG masking
			hdr[5] <= 8'h00;
			hdr[6] <= 8'h40;
			hdr[7] <= 8'h10;
			for (int i = 8; i < HDR_BYTES; i++)
				hdr[i] <= 8'h00;
		end
	end

endmodule

/* hw/rom_byte_fetch.sv */
// Paced byte fetch; BYTE_PERIOD must be a power of two, at least 2, and bounds the byte rate
`timescale 1ns/1ps

module rom_byte_fetch #(
	parameter int BYTE_PERIOD = 16
) (
	input  logic       clk,
	input  logic       host_reset_loader,
	input  logic       fifo_empty_i,
	output logic       fifo_rd_o,
	input  logic [7:0] fifo_byte_i,
	input  logic       loader_done_i,
	input  logic       host_run_i,
	output logic       byte_stb_o,
	output logic [7:0] byte_data_o,
	output logic       downloading_o
);

	localparam int CNT_W = $clog2(BYTE_PERIOD);

	logic [CNT_W-1:0] pace_cnt;     // Free running
	logic             end_download; // Host has finished sending

	// Pop only in the last phase of each window
	assign fifo_rd_o = (pace_cnt == CNT_W'(BYTE_PERIOD - 1)) && !fifo_empty_i && !loader_done_i;

	// ----------------------------------------
	// Pacing and strobe
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (host_reset_loader) begin
			pace_cnt   <= '0;
			byte_stb_o <= 1'b0;
		end else begin
			pace_cnt   <= pace_cnt + 1'b1;
			byte_stb_o <= fifo_rd_o;  // One cycle after pop
		end
	end

	always_ff @(posedge clk) begin
		if (fifo_rd_o)
			byte_data_o <= fifo_byte_i;  // Held until next pop
	end

	// ----------------------------------------
	// Downloading flag
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (host_reset_loader) begin
			downloading_o <= 1'b1;
			end_download  <= 1'b0;
		end else begin
			if (host_run_i)
				end_download <= 1'b1;  // Sticky
			// Drains the buffer before dropping
			if (end_download && fifo_empty_i)
				downloading_o <= 1'b0;
		end
	end

endmodule

/* hw/word_byte_fifo.sv */
// Single-clock word-in byte-out FIFO; FIFO_WORDS must be a power of two, at least 2
`timescale 1ns/1ps

module word_byte_fifo #(
	parameter int FIFO_WORDS = 16
) (
	input  logic                                clk,
	input  logic                                host_reset_loader,
	input  logic                                wr_en_i,
	input  logic [rom_loader_pkg::BOOT_WORD_W-1:0] wr_word_i,
	output logic                                full_o,
	input  logic                                rd_en_i,
	output logic [7:0]                          rd_byte_o,
	output logic                                empty_o
);

	import rom_loader_pkg::*;

	localparam int AW = $clog2(FIFO_WORDS);

	logic [BOOT_WORD_W-1:0] mem [FIFO_WORDS];
	logic [AW:0]            wr_ptr;  // Extra bit tells wrap
	logic [AW:0]            rd_ptr;
	logic [1:0]             lane;    // Byte within current word, 3 is MSB
	logic                   do_wr;
	logic                   do_rd;

	// ----------------------------------------
	// Status
	// ----------------------------------------
	assign empty_o = (wr_ptr == rd_ptr);
	assign full_o  = (wr_ptr[AW] != rd_ptr[AW]) &&
	                 (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	assign do_wr = wr_en_i && !full_o;   // Overflow dropped
	assign do_rd = rd_en_i && !empty_o;  // Underflow ignored

	// Show-ahead byte, MSB first
	assign rd_byte_o = mem[rd_ptr[AW-1:0]][lane*8 +: 8];

	// Word store
	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr[AW-1:0]] <= wr_word_i;
	end

	// ----------------------------------------
	// Pointers
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (host_reset_loader) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			lane   <= 2'd3;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_rd) begin
				if (lane == 2'd0) begin
					// Last byte of the word gone, free the slot
					rd_ptr <= rd_ptr + 1'b1;
					lane   <= 2'd3;
				end else begin
					lane <= lane - 2'd1;
				end
			end
		end
	end

endmodule

/* hw/boot_word_intake.sv */
// Host word intake; the host must hold data stable while req is high and drop req after ack
`timescale 1ns/1ps

module boot_word_intake (
	input  logic                                clk,
	input  logic                                host_reset_loader,
	input  logic [rom_loader_pkg::BOOT_WORD_W-1:0] boot_data_i,
	input  logic                                boot_req_i,
	output logic                                boot_ack_o,
	input  logic                                fifo_full_i,
	output logic                                fifo_wr_o,
	output logic [rom_loader_pkg::BOOT_WORD_W-1:0] fifo_word_o
);

	// Two phases, accept then recover
	typedef enum logic {
		BI_IDLE,  // Waiting for a request
		BI_ACK    // Ack and write out, then back to idle
	} intake_state_t;

	intake_state_t state;

	// ----------------------------------------
	// Acceptance FSM
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (host_reset_loader) begin
			state      <= BI_IDLE;
			boot_ack_o <= 1'b0;
			fifo_wr_o  <= 1'b0;
		end else begin
			unique case (state)
				BI_IDLE: begin
					// Room in the buffer? otherwise the word just waits
					if (boot_req_i && !fifo_full_i) begin
						boot_ack_o <= 1'b1;
						fifo_wr_o  <= 1'b1;
						state      <= BI_ACK;
					end else begin
						boot_ack_o <= 1'b0;
						fifo_wr_o  <= 1'b0;
					end
				end
				BI_ACK: begin
					boot_ack_o <= 1'b0;  // Single cycle pulse
					fifo_wr_o  <= 1'b0;
					state      <= BI_IDLE;  // One dead cycle lets req drop
				end
			endcase
		end
	end

	// Word register, loaded on acceptance
	always_ff @(posedge clk) begin
		if (state == BI_IDLE && boot_req_i && !fifo_full_i)
			fifo_word_o <= boot_data_i;
	end

endmodule

/* hw/rom_loader_pkg.sv */
// Shared constants and types for the ROM download path; addresses assume a 22-bit byte space
package rom_loader_pkg;

	// ----------------------------------------
	// Widths
	// ----------------------------------------
	localparam int MEM_ADDR_W  = 22;  // Byte address into ROM memory
	localparam int BOOT_WORD_W = 32;  // Host boot word
	localparam int FLAGS_W     = 32;  // Mapper flags word
	localparam int HDR_BYTES   = 16;  // iNES / FDS header length

	// ----------------------------------------
	// Load addresses
	// ----------------------------------------
	localparam logic [MEM_ADDR_W-1:0] PRG_BASE       = 22'h000000;
	localparam logic [MEM_ADDR_W-1:0] CHR_BASE       = 22'h200000;  // Bit 21
	localparam logic [MEM_ADDR_W-1:0] FDS_SKIP_BASE  = 22'h010010;  // Disk image, header skipped
	localparam logic [MEM_ADDR_W-1:0] BIOS_SKIP_BASE = 22'h000010;  // BIOS, header skipped
	localparam logic [MEM_ADDR_W-1:0] FDS_RAW_BASE   = 22'h010020;  // Disk image, no header

	// File type as reported by the host
	typedef enum logic [7:0] {
		ROM_NES  = 8'd0,  // NES ROM, or FDS with header
		ROM_BIOS = 8'd2,  // FDS BIOS image
		ROM_FDS  = 8'd3   // Raw FDS disk
	} rom_kind_t;

	// Loader FSM
	typedef enum logic [2:0] {
		LS_HEADER,  // Collecting 16 header bytes
		LS_PRG,     // Counted PRG payload
		LS_CHR,     // Counted CHR payload
		LS_BAD,     // Unknown file
		LS_RAW      // Everything until the host stops
	} load_state_t;

	// ----------------------------------------
	// Mapper flags layout
	// ----------------------------------------
	localparam int FLG_MAPPER_LSB   = 0;   // 8 bits
	localparam int FLG_PRG_LSB      = 8;   // 3 bits
	localparam int FLG_CHR_LSB      = 11;  // 3 bits
	localparam int FLG_MIRROR_BIT   = 14;
	localparam int FLG_CHR_RAM_BIT  = 15;
	localparam int FLG_FOUR_SCR_BIT = 16;
	localparam int FLG_EXT_LSB      = 17;  // 8 bits, iNES 2.0 byte 8
	// Bits 31..25 stay zero

endpackage
